/* dsp_backend_settings.svh */
`ifndef DSP_BACKEND_SETTINGS_SVH
`define DSP_BACKEND_SETTINGS_SVH

////////////////////////////////////////////////////////////
// datapath sizes
////////////////////////////////////////////////////////////
`define DSP_LANES       4
`define DSP_CODE_W      8   // signed adc code
`define DSP_EST_W       8   // signed equalized value
`define DSP_COEF_W      16  // config data word
`define DSP_WEIGHT_W    8   // ffe weight, low bits of a coef write
`define DSP_THRESH_W    10
`define DSP_SHIFT_W     3
`define DSP_FFE_LEN     3
`define DSP_HIST_DEPTH  3   // oldest word lines up with the sliced word
`define DSP_ADDR_W      3

////////////////////////////////////////////////////////////
// config address map
////////////////////////////////////////////////////////////
`define DSP_REG_W0      0   // weight on the current symbol
`define DSP_REG_W1      1
`define DSP_REG_W2      2   // weight on the symbol two back
`define DSP_REG_H0      3
`define DSP_REG_H1      4
`define DSP_REG_CTRL    5   // thresh and both shifts

`endif

/* dsp_backend_pkg.sv */
`default_nettype none

`include "dsp_backend_settings.svh"

package dsp_backend_pkg;

	typedef logic signed [`DSP_CODE_W-1:0] code_t;
	typedef code_t [`DSP_LANES-1:0] code_word_t;  // lane 0 is the oldest symbol

	typedef logic signed [`DSP_EST_W-1:0] est_t;
	typedef est_t [`DSP_LANES-1:0] est_word_t;

	typedef logic [`DSP_LANES-1:0] bit_word_t;

	// d0 is the newest registered word
	typedef struct packed {
		code_word_t d2;
		code_word_t d1;
		code_word_t d0;
	} code_hist_t;

	typedef logic signed [`DSP_WEIGHT_W-1:0] weight_t;
	typedef logic signed [`DSP_COEF_W-1:0] chan_est_t;
	typedef logic signed [`DSP_THRESH_W-1:0] thresh_t;
	typedef logic [`DSP_SHIFT_W-1:0] shift_t;

	typedef struct packed {
		thresh_t thresh;
		shift_t  ffe_shift;
		shift_t  mlsd_shift;
	} cfg_ctrl_t;

	// one write word, read as a coefficient or as the control fields
	typedef union packed {
		logic signed [`DSP_COEF_W-1:0] coef;
		cfg_ctrl_t                     ctrl;
	} cfg_word_u;

	typedef struct packed {
		weight_t   w0;
		weight_t   w1;
		weight_t   w2;
		chan_est_t h0;
		chan_est_t h1;
		thresh_t   thresh;
		shift_t    ffe_shift;
		shift_t    mlsd_shift;
	} dsp_cfg_t;

endpackage

`default_nettype wire

/* dsp_cfg_regs.sv */
`default_nettype none

`include "dsp_backend_settings.svh"

module dsp_cfg_regs (
	input  wire logic                       clk,
	input  wire logic                       rstb,
	input  wire logic                       cfg_we_i,
	input  wire logic [`DSP_ADDR_W-1:0]     cfg_addr_i,
	input  wire dsp_backend_pkg::cfg_word_u cfg_data_i,
	output dsp_backend_pkg::dsp_cfg_t       cfg_o
);
	import dsp_backend_pkg::*;

	////////////////////////////////////////////////////////////
	// write decode
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			cfg_o <= '0;
		end else if (cfg_we_i) begin
			case (cfg_addr_i)
				`DSP_REG_W0: begin
					cfg_o.w0 <= cfg_data_i.coef[`DSP_WEIGHT_W-1:0];
				end
				`DSP_REG_W1: begin
					cfg_o.w1 <= cfg_data_i.coef[`DSP_WEIGHT_W-1:0];
				end
				`DSP_REG_W2: begin
					cfg_o.w2 <= cfg_data_i.coef[`DSP_WEIGHT_W-1:0];
				end
				`DSP_REG_H0: begin
					cfg_o.h0 <= cfg_data_i.coef;  // full width estimate
				end
				`DSP_REG_H1: begin
					cfg_o.h1 <= cfg_data_i.coef;
				end
				`DSP_REG_CTRL: begin
					cfg_o.thresh     <= cfg_data_i.ctrl.thresh;
					cfg_o.ffe_shift  <= cfg_data_i.ctrl.ffe_shift;
					cfg_o.mlsd_shift <= cfg_data_i.ctrl.mlsd_shift;
				end
				default: begin
					// unmapped address, nothing changes
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* code_history.sv */
`default_nettype none

`include "dsp_backend_settings.svh"

module code_history (
	input  wire logic                        clk,
	input  wire logic                        rstb,
	input  wire dsp_backend_pkg::code_word_t codes_i,
	output dsp_backend_pkg::code_hist_t      hist_o
);
	import dsp_backend_pkg::*;

	code_word_t hist_q [`DSP_HIST_DEPTH];  // [0] holds the word from the last edge

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			for (int i = 0; i < `DSP_HIST_DEPTH; i++) begin
				hist_q[i] <= '0;
			end
		end else begin
			hist_q[0] <= codes_i;
			for (int i = 1; i < `DSP_HIST_DEPTH; i++) begin
				hist_q[i] <= hist_q[i-1];
			end
		end
	end

	// ffe works on the two newest words
	assign hist_o.d0 = hist_q[0];
	assign hist_o.d1 = hist_q[1];
	// same word that the slicer is deciding on this cycle
	assign hist_o.d2 = hist_q[`DSP_HIST_DEPTH-1];

endmodule

`default_nettype wire

/* ffe_filter.sv */
`default_nettype none

`include "dsp_backend_settings.svh"

module ffe_filter (
	input  wire logic                        clk,
	input  wire logic                        rstb,
	input  wire dsp_backend_pkg::code_hist_t hist_i,
	input  wire dsp_backend_pkg::dsp_cfg_t   cfg_i,
	output dsp_backend_pkg::est_word_t       est_o
);
	import dsp_backend_pkg::*;

	localparam int ACC_W = `DSP_CODE_W + `DSP_WEIGHT_W + 2;  // room for three products
	localparam int PAST  = `DSP_FFE_LEN - 1;                 // symbols borrowed from d1

	localparam logic signed [ACC_W-1:0] EST_MAX = ACC_W'((1 << (`DSP_EST_W - 1)) - 1);
	localparam logic signed [ACC_W-1:0] EST_MIN = ACC_W'(-(1 << (`DSP_EST_W - 1)));

	weight_t   w   [`DSP_FFE_LEN];
	code_t     sym [`DSP_LANES + PAST];  // tail of the previous word, then the current word
	est_word_t est_d;

	assign w[0] = cfg_i.w0;
	assign w[1] = cfg_i.w1;
	assign w[2] = cfg_i.w2;

	genvar gi;
	for (gi = 0; gi < PAST; gi = gi + 1) begin : g_past
		assign sym[gi] = hist_i.d1[`DSP_LANES - PAST + gi];
	end
	for (gi = 0; gi < `DSP_LANES; gi = gi + 1) begin : g_cur
		assign sym[PAST + gi] = hist_i.d0[gi];
	end

	////////////////////////////////////////////////////////////
	// fir, shift, saturate
	////////////////////////////////////////////////////////////
	always_comb begin
		logic signed [ACC_W-1:0] acc;
		logic signed [ACC_W-1:0] shifted;
		for (int k = 0; k < `DSP_LANES; k++) begin
			acc = '0;
			for (int j = 0; j < `DSP_FFE_LEN; j++) begin
				acc = acc + w[j] * sym[PAST + k - j];  // tap j looks j symbols back
			end
			shifted = acc >>> cfg_i.ffe_shift;
			if (shifted > EST_MAX) begin
				est_d[k] = EST_MAX[`DSP_EST_W-1:0];
			end else if (shifted < EST_MIN) begin
				est_d[k] = EST_MIN[`DSP_EST_W-1:0];
			end else begin
				est_d[k] = shifted[`DSP_EST_W-1:0];
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			est_o <= '0;
		end else begin
			est_o <= est_d;
		end
	end

endmodule

`default_nettype wire

/* bit_slicer.sv */
`default_nettype none

`include "dsp_backend_settings.svh"

module bit_slicer (
	input  wire logic                       clk,
	input  wire logic                       rstb,
	input  wire dsp_backend_pkg::est_word_t est_i,
	input  wire dsp_backend_pkg::dsp_cfg_t  cfg_i,
	output dsp_backend_pkg::bit_word_t      bits_o
);
	import dsp_backend_pkg::*;

	bit_word_t above;

	// signed compare, est is sign extended up to the threshold width
	always_comb begin
		for (int k = 0; k < `DSP_LANES; k++) begin
			above[k] = est_i[k] > cfg_i.thresh;
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			bits_o <= '0;
		end else begin
			bits_o <= above;
		end
	end

endmodule

`default_nettype wire

/* mlsd_checker.sv */
`default_nettype none

`include "dsp_backend_settings.svh"

module mlsd_checker (
	input  wire logic                        clk,
	input  wire logic                        rstb,
	input  wire dsp_backend_pkg::bit_word_t  bits_i,
	input  wire dsp_backend_pkg::code_hist_t hist_i,
	input  wire dsp_backend_pkg::dsp_cfg_t   cfg_i,
	output dsp_backend_pkg::bit_word_t       checked_o
);
	import dsp_backend_pkg::*;

	localparam int SUM_W = `DSP_COEF_W + 1;  // holds -h for h at its minimum
	localparam int ERR_W = SUM_W + 1;

	logic      last_q;     // lane 3 of the previous sliced word
	bit_word_t prev_bits;
	bit_word_t flip;

	// |code - ((h0*s(b) + h1*s(p)) >>> sh)|, s maps a bit to +1 / -1
	function automatic logic [ERR_W-1:0] abs_err(
		input code_t     code,
		input chan_est_t h0,
		input chan_est_t h1,
		input logic      b,
		input logic      p,
		input shift_t    sh
	);
		logic signed [SUM_W-1:0] t0;
		logic signed [SUM_W-1:0] t1;
		logic signed [ERR_W-1:0] diff;
		t0 = b ? h0 : -h0;
		t1 = p ? h1 : -h1;
		diff = code - ((t0 + t1) >>> sh);
		return diff[ERR_W-1] ? -diff : diff;
	endfunction

	assign prev_bits = {bits_i[`DSP_LANES-2:0], last_q};

	////////////////////////////////////////////////////////////
	// keep or flip, per lane
	////////////////////////////////////////////////////////////
	always_comb begin
		logic [ERR_W-1:0] err_keep;
		logic [ERR_W-1:0] err_flip;
		for (int k = 0; k < `DSP_LANES; k++) begin
			err_keep = abs_err(hist_i.d2[k], cfg_i.h0, cfg_i.h1,
				bits_i[k], prev_bits[k], cfg_i.mlsd_shift);
			err_flip = abs_err(hist_i.d2[k], cfg_i.h0, cfg_i.h1,
				~bits_i[k], prev_bits[k], cfg_i.mlsd_shift);
			flip[k] = err_flip < err_keep;  // ties keep the sliced bit
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			last_q    <= 1'b0;
			checked_o <= '0;
		end else begin
			last_q    <= bits_i[`DSP_LANES-1];  // sliced value, not the corrected one
			checked_o <= bits_i ^ flip;
		end
	end

endmodule

`default_nettype wire

/* dsp_backend.sv */
`default_nettype none

`include "dsp_backend_settings.svh"

module dsp_backend (
	input  wire logic                        clk,
	input  wire logic                        rstb,
	input  wire dsp_backend_pkg::code_word_t codes_i,
	input  wire logic                        cfg_we_i,
	input  wire logic [`DSP_ADDR_W-1:0]      cfg_addr_i,
	input  wire dsp_backend_pkg::cfg_word_u  cfg_data_i,
	output wire dsp_backend_pkg::est_word_t  est_o,
	output wire dsp_backend_pkg::bit_word_t  sliced_o,
	output wire dsp_backend_pkg::bit_word_t  checked_o
);
	import dsp_backend_pkg::*;

	wire dsp_cfg_t   cfg;
	wire code_hist_t hist;

	dsp_cfg_regs u_cfg_regs (
		.clk        (clk),
		.rstb       (rstb),
		.cfg_we_i   (cfg_we_i),
		.cfg_addr_i (cfg_addr_i),
		.cfg_data_i (cfg_data_i),
		.cfg_o      (cfg)
	);

	code_history u_code_history (
		.clk     (clk),
		.rstb    (rstb),
		.codes_i (codes_i),
		.hist_o  (hist)
	);

	////////////////////////////////////////////////////////////
	// ffe -> slicer -> sequence check, one register each
	////////////////////////////////////////////////////////////
	ffe_filter u_ffe_filter (
		.clk    (clk),
		.rstb   (rstb),
		.hist_i (hist),
		.cfg_i  (cfg),
		.est_o  (est_o)
	);

	bit_slicer u_bit_slicer (
		.clk    (clk),
		.rstb   (rstb),
		.est_i  (est_o),
		.cfg_i  (cfg),
		.bits_o (sliced_o)
	);

	mlsd_checker u_mlsd_checker (
		.clk       (clk),
		.rstb      (rstb),
		.bits_i    (sliced_o),
		.hist_i    (hist),
		.cfg_i     (cfg),
		.checked_o (checked_o)
	);

endmodule

`default_nettype wire

/* dsp_backend_chk.sv */
`default_nettype none

`include "dsp_backend_settings.svh"

module dsp_backend_chk (
	input wire logic                       clk,
	input wire logic                       rstb,
	input wire logic                       cfg_we_i,
	input wire logic [`DSP_ADDR_W-1:0]     cfg_addr_i,
	input wire dsp_backend_pkg::dsp_cfg_t  cfg_i,
	input wire dsp_backend_pkg::est_word_t est_i,
	input wire dsp_backend_pkg::bit_word_t sliced_i,
	input wire dsp_backend_pkg::bit_word_t checked_i
);
	import dsp_backend_pkg::*;

	a_reset_zero: assert property (@(posedge clk)
		!rstb |-> (est_i == '0 && sliced_i == '0 && checked_i == '0))
		else $error("outputs not zero in reset");

	a_unmapped_write: assert property (@(posedge clk) disable iff (!rstb)
		(cfg_we_i && cfg_addr_i > `DSP_REG_CTRL) |=> $stable(cfg_i))
		else $error("unmapped write changed the settings");

	// a flip needs a non-zero main cursor
	a_flip_needs_h0: assert property (@(posedge clk) disable iff (!rstb)
		(checked_i != $past(sliced_i)) |-> ($past(cfg_i.h0) != '0))
		else $error("bit flipped with h0 at zero");

endmodule

bind dsp_backend dsp_backend_chk u_chk (.clk(clk), .rstb(rstb), .cfg_we_i(cfg_we_i),
	.cfg_addr_i(cfg_addr_i), .cfg_i(cfg), .est_i(est_o), .sliced_i(sliced_o),
	.checked_i(checked_o));

`default_nettype wire

/* dsp_backend_tb.sv */
`default_nettype none

`include "dsp_backend_settings.svh"

module dsp_backend_tb;
	import dsp_backend_pkg::*;

	localparam int TOTAL_CYCLES = 2 + 42 + 140 + 126 + 66 + 200;

	logic clk = 1'b0;
	logic rstb = 1'b0;
	code_word_t codes_i = '0;
	logic cfg_we_i = 1'b0;
	logic [`DSP_ADDR_W-1:0] cfg_addr_i = '0;
	cfg_word_u cfg_data_i = '0;
	est_word_t est_o;
	bit_word_t sliced_o;
	bit_word_t checked_o;

	int unsigned seed = 28;
	int errors = 0;
	int checks = 0;
	int flips = 0;
	int test_err = 0;
	int m_hist[3][4];
	int m_est[4];
	int m_sl[4];
	int m_chk[4];
	int m_last;
	int m_w[3];
	int m_h0;
	int m_h1;
	int m_thr;
	int m_fsh;
	int m_msh;
	logic [31:0] drv_c = '0;
	logic [31:0] code_d1 = '0;
	logic [31:0] code_d2 = '0;
	logic drv_we = 1'b0;
	logic [2:0] drv_a = '0;
	logic [15:0] drv_d = '0;
	bit pass_chk = 0;

	dsp_backend u_dut (.clk(clk), .rstb(rstb), .codes_i(codes_i), .cfg_we_i(cfg_we_i),
		.cfg_addr_i(cfg_addr_i), .cfg_data_i(cfg_data_i), .est_o(est_o),
		.sliced_o(sliced_o), .checked_o(checked_o));

	initial begin
		forever #10 clk = ~clk;
	end

	initial begin
		#((TOTAL_CYCLES + 50) * 20);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Verification failed");
		$finish;
	end

	function automatic int unsigned rnd();
		seed = seed * 32'd1664525 + 32'd1013904223;  // lcg
		return seed >> 8;
	endfunction

	function automatic int rnd_range(int lo, int hi);
		return lo + int'(rnd() % (hi - lo + 1));
	endfunction

	function automatic logic [31:0] rnd_word();
		logic [31:0] a, b;
		a = rnd();
		b = rnd();
		return {a[15:0], b[15:0]};
	endfunction

	function automatic logic [15:0] ctrl_word(int thr, int f, int m);
		logic [31:0] t, fs, ms;
		t = thr;
		fs = f;
		ms = m;
		return {t[9:0], fs[2:0], ms[2:0]};
	endfunction

	// received code predicted for bit b after bit p
	function automatic int pred(int b, int p);
		return ((b != 0 ? m_h0 : -m_h0) + (p != 0 ? m_h1 : -m_h1)) >>> m_msh;
	endfunction

	function automatic int iabs(int v);
		return v < 0 ? -v : v;
	endfunction

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("Error: %0t: %s mismatch, expected %h got %h", $time, what, exp, got);
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model, one clock edge
	////////////////////////////////////////////////////////////
	task automatic model_clock();
		int est_n[4], sl_n[4], chk_n[4];
		int acc, s, p, ek, ef;
		for (int k = 0; k < 4; k++) begin
			acc = 0;
			for (int j = 0; j < 3; j++) begin
				s = (k - j < 0) ? m_hist[1][4 + k - j] : m_hist[0][k - j];
				acc += m_w[j] * s;
			end
			acc = acc >>> m_fsh;
			est_n[k] = acc > 127 ? 127 : (acc < -128 ? -128 : acc);
			sl_n[k] = m_est[k] > m_thr ? 1 : 0;
			p = (k == 0) ? m_last : m_sl[k - 1];
			ek = iabs(m_hist[2][k] - pred(m_sl[k], p));
			ef = iabs(m_hist[2][k] - pred(1 - m_sl[k], p));
			chk_n[k] = ef < ek ? 1 - m_sl[k] : m_sl[k];
			if (chk_n[k] != m_sl[k]) flips++;
		end
		m_last = m_sl[3];
		m_est = est_n;
		m_sl = sl_n;
		m_chk = chk_n;
		m_hist[2] = m_hist[1];
		m_hist[1] = m_hist[0];
		for (int k = 0; k < 4; k++) m_hist[0][k] = $signed(drv_c[8*k +: 8]);
		if (drv_we) begin
			case (drv_a)
				0, 1, 2: m_w[drv_a] = $signed(drv_d[7:0]);
				3: m_h0 = $signed(drv_d);
				4: m_h1 = $signed(drv_d);
				5: begin
					m_thr = $signed(drv_d[15:6]);
					m_fsh = drv_d[5:3];
					m_msh = drv_d[2:0];
				end
				default: ;  // unmapped
			endcase
		end
	endtask

	// check the last edge, then drive on the falling edge
	task automatic step(input logic [31:0] c, input logic we, input logic [2:0] a,
		input logic [15:0] d);
		logic [31:0] e_est;
		logic [3:0] e_sl, e_chk;
		@(negedge clk);
		model_clock();
		for (int k = 0; k < 4; k++) begin
			e_est[8*k +: 8] = m_est[k][7:0];
			e_sl[k] = m_sl[k][0];
			e_chk[k] = m_chk[k][0];
		end
		check_val("est_o", e_est, est_o);
		check_val("sliced_o", {28'd0, e_sl}, {28'd0, sliced_o});
		check_val("checked_o", {28'd0, e_chk}, {28'd0, checked_o});
		if (pass_chk) check_val("est_o pass-through", code_d2, est_o);
		code_d2 = code_d1;
		code_d1 = c;
		drv_c = c;
		drv_we = we;
		drv_a = a;
		drv_d = d;
		codes_i = c;
		cfg_we_i = we;
		cfg_addr_i = a;
		cfg_data_i = d;
	endtask

	task automatic write_reg(input logic [2:0] a, input logic [15:0] d);
		step(rnd_word(), 1'b1, a, d);
	endtask

	task automatic end_test(input string name);
		$display("test %s done, %0d errors", name, errors - test_err);
		test_err = errors;
	endtask

	initial begin
		logic [31:0] c;
		int v;
		for (int i = 0; i < 3; i++) begin
			for (int k = 0; k < 4; k++) begin
				m_hist[i][k] = 0;
			end
		end
		m_est = '{0, 0, 0, 0};
		m_sl = '{0, 0, 0, 0};
		m_chk = '{0, 0, 0, 0};
		m_w = '{0, 0, 0};
		{m_last, m_h0, m_h1, m_thr, m_fsh, m_msh} = '0;
		repeat (2) @(negedge clk);
		rstb = 1'b1;

		repeat (30) step(rnd_word(), 1'b0, 3'd0, 16'd0);
		write_reg(3'd6, 16'(rnd()));
		write_reg(3'd7, 16'(rnd()));
		repeat (10) step(rnd_word(), 1'b0, 3'd0, 16'd0);
		check_val("est_o idle", 32'd0, est_o);
		check_val("sliced_o idle", 32'd0, {28'd0, sliced_o});
		check_val("checked_o idle", 32'd0, {28'd0, checked_o});
		end_test("reset and unmapped writes");

		write_reg(3'd0, 16'd1);
		write_reg(3'd1, 16'd0);
		write_reg(3'd2, 16'd0);
		write_reg(3'd5, ctrl_word(0, 0, 0));
		for (int i = 0; i < 40; i++) begin
			pass_chk = i >= 2;
			step(rnd_word(), 1'b0, 3'd0, 16'd0);
		end
		pass_chk = 0;
		repeat (4) begin
			for (int a = 0; a < 3; a++) write_reg(3'(a), 16'(rnd()));
			write_reg(3'd5, ctrl_word(0, rnd_range(0, 7), 0));
			repeat (20) step(rnd_word(), 1'b0, 3'd0, 16'd0);
		end
		end_test("ffe");

		repeat (6) begin
			write_reg(3'd5, ctrl_word(rnd_range(-150, 150), rnd_range(0, 4), 0));
			repeat (20) step(rnd_word(), 1'b0, 3'd0, 16'd0);
		end
		end_test("slicer threshold");

		write_reg(3'd0, 16'd1);
		write_reg(3'd1, 16'd0);
		write_reg(3'd2, 16'd0);
		v = rnd_range(8, 23);
		write_reg(3'd3, 16'(v));
		write_reg(3'd4, 16'(v + rnd_range(30, 60)));
		write_reg(3'd5, ctrl_word(0, 0, rnd_range(0, 2)));
		flips = 0;
		repeat (60) begin
			// small positive codes after a one favor the flipped bit
			for (int k = 0; k < 4; k++) begin
				v = (rnd() % 3 == 0) ? rnd_range(1, 3) : rnd_range(20, 100);
				if (rnd() % 2 == 0 && v > 3) v = -v;
				c[8*k +: 8] = 8'(v);
			end
			step(c, 1'b0, 3'd0, 16'd0);
		end
		check_val("flips seen", 32'd1, {31'd0, flips > 0});
		end_test("sequence correction");

		repeat (200) begin
			if (rnd() % 4 == 0) step(rnd_word(), 1'b1, 3'(rnd()), 16'(rnd()));
			else step(rnd_word(), 1'b0, 3'd0, 16'd0);
		end
		end_test("config mid-stream");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dsp_backend.f */
+incdir+.
dsp_backend_pkg.sv
dsp_cfg_regs.sv
code_history.sv
ffe_filter.sv
bit_slicer.sv
mlsd_checker.sv
dsp_backend.sv
dsp_backend_chk.sv
dsp_backend_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f dsp_backend.f --top-module dsp_backend_tb -o sim_dsp_backend

./obj_dir/sim_dsp_backend > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
	exit 0
fi
exit 1
